//--- build.f
+incdir+src
src/dcache_pkg.sv
src/dcache_meta.sv
src/dcache_ways.sv
src/dcache_ctrl.sv
src/dcache_top.sv
testbench/tb_mem_slave.sv
testbench/tb_dcache.sv

//--- run.sh
#!/bin/sh
# build the dcache testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_dcache -f build.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_dcache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -qx "Finished with no errors" sim.log; then
    exit 0
fi
exit 1

//--- src/dcache_ctrl.sv
`include "dcache_params.svh"

module dcache_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req,
    input  dcache_pkg::cpu_req_t          cpu_req,
    output logic                          ack,
    output logic [31:0]                   rdata,
    output logic                          ar_valid,
    output dcache_pkg::mem_ar_t           ar,
    input  logic                          ar_ready,
    input  logic                          r_valid,
    input  logic [31:0]                   r_data,
    input  logic                          r_last,
    output logic                          r_ready,
    output logic                          aw_valid,
    output dcache_pkg::mem_aw_t           aw,
    input  logic                          aw_ready,
    output logic                          w_valid,
    output logic [31:0]                   w_data,
    output logic                          w_last,
    input  logic                          w_ready,
    input  logic                          hit,
    input  dcache_pkg::way_t              hit_way,
    input  dcache_pkg::way_t              victim_way,
    input  logic                          victim_dirty,
    input  logic [1:0][`DC_LEN_TAG-1:0]   victim_tag,
    input  logic [1:0][31:0]              rd_data,
    output logic [`DC_LEN_INDEX-1:0]      ram_index,
    output logic [`DC_LEN_LINE-3:0]       ram_word,
    output dcache_pkg::way_t              wr_way,
    output logic [3:0]                    wr_mask,
    output logic [31:0]                   wr_data,
    output logic                          tag_we,
    output logic                          meta_fill,
    output logic                          meta_touch,
    output logic                          meta_clean
);
    import dcache_pkg::*;

    typedef enum logic [2:0] {
        IDLE, LOOKUP, WB_READ, WB_SEND, REFILL, DONE
    } state_t;

    state_t   state;
    logic     rd_ok;       // RAM output belongs to the request
    way_t     vict_q;
    dc_addr_u wb_addr;
    logic [$clog2(`DC_NR_WORDS):0] cnt;
    logic [31:0] line_buf [`DC_NR_WORDS];

    logic [`DC_LEN_LINE-3:0] slot;
    logic                    lookup_hit;
    logic                    beat;

    assign slot       = cnt[`DC_LEN_LINE-3:0];
    assign lookup_hit = (state == LOOKUP) && rd_ok && hit;
    assign beat       = (state == REFILL) && r_valid && r_ready;

    // RAM port steering
    assign ram_index = cpu_req.addr.f.index;
    assign ram_word  = (state == WB_READ || state == REFILL) ? slot : cpu_req.addr.f.word;
    assign wr_way    = (state == LOOKUP) ? hit_way : vict_q;
    assign wr_data   = (state == REFILL) ? r_data : cpu_req.wdata;

    always_comb begin
        wr_mask = 4'h0;
        if (beat) begin
            wr_mask = 4'hf;
        end else if (lookup_hit && cpu_req.write) begin
            wr_mask = cpu_req.mask;   // store merges on the ack edge
        end
    end

    assign tag_we     = beat && r_last;
    assign meta_fill  = beat && r_last;
    assign meta_touch = lookup_hit;
    assign meta_clean = (state == WB_SEND) && w_valid && w_ready && w_last;

    assign ar.addr.word = {cpu_req.addr.word[`DC_ADDR_W-1:`DC_LEN_LINE], {`DC_LEN_LINE{1'b0}}};
    assign aw.addr      = wb_addr;
    assign w_data       = line_buf[slot];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            rd_ok    <= 1'b0;
            ack      <= 1'b0;
            ar_valid <= 1'b0;
            r_ready  <= 1'b0;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            w_last   <= 1'b0;
            cnt      <= '0;
            vict_q   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        rd_ok <= 1'b0;
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    rd_ok <= 1'b1;  // first cycle only reads
                    if (rd_ok && hit) begin
                        rdata <= rd_data[hit_way];
                        ack   <= 1'b1;
                        state <= DONE;
                    end else if (rd_ok) begin
                        vict_q          <= victim_way;
                        cnt             <= '0;
                        wb_addr.f.tag   <= victim_tag[victim_way];
                        wb_addr.f.index <= cpu_req.addr.f.index;
                        wb_addr.f.word  <= '0;
                        wb_addr.f.offs  <= '0;
                        if (victim_dirty) begin
                            state <= WB_READ;
                        end else begin
                            ar_valid <= 1'b1;
                            r_ready  <= 1'b1;
                            state    <= REFILL;
                        end
                    end
                end
                WB_READ: begin
                    // word cnt-1 comes out of the RAM now
                    if (cnt != 0) begin
                        line_buf[slot - 1'b1] <= rd_data[vict_q];
                    end
                    if (cnt == `DC_NR_WORDS) begin
                        cnt      <= '0;
                        aw_valid <= 1'b1;
                        state    <= WB_SEND;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                WB_SEND: begin
                    if (aw_valid && aw_ready) begin
                        aw_valid <= 1'b0;
                        w_valid  <= 1'b1;
                        w_last   <= (`DC_NR_WORDS == 1);
                    end
                    if (w_valid && w_ready) begin
                        if (w_last) begin
                            w_valid  <= 1'b0;
                            w_last   <= 1'b0;
                            cnt      <= '0;
                            ar_valid <= 1'b1;
                            r_ready  <= 1'b1;
                            state    <= REFILL;
                        end else begin
                            cnt    <= cnt + 1'b1;
                            w_last <= (cnt + 1'b1 == `DC_NR_WORDS - 1);
                        end
                    end
                end
                REFILL: begin
                    if (ar_valid && ar_ready) begin
                        ar_valid <= 1'b0;
                    end
                    if (beat) begin
                        cnt <= cnt + 1'b1;
                        if (r_last) begin
                            r_ready <= 1'b0;
                            rd_ok   <= 1'b0;  // look up again on the new line
                            state   <= LOOKUP;
                        end
                    end
                end
                DONE: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- src/dcache_meta.sv
`include "dcache_params.svh"

module dcache_meta (
    input  logic                          clk,
    input  logic                          rst,
    input  dcache_pkg::dc_addr_u          addr,
    input  logic [1:0][`DC_LEN_TAG-1:0]   tag_rd,
    input  logic                          write,
    input  logic                          meta_fill,
    input  logic                          meta_touch,
    input  logic                          meta_clean,
    input  dcache_pkg::way_t              fill_way,
    output logic                          hit,
    output dcache_pkg::way_t              hit_way,
    output dcache_pkg::way_t              victim_way,
    output logic                          victim_dirty
);

    logic [1:0] valid [`DC_NR_SETS];
    logic [1:0] dirty [`DC_NR_SETS];
    logic       lru   [`DC_NR_SETS];  // way to replace next

    logic [`DC_LEN_INDEX-1:0] set;
    logic [1:0]               match;

    assign set = addr.f.index;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            match[w] = valid[set][w] && (tag_rd[w] == addr.f.tag);
        end
    end

    assign hit          = |match;
    assign hit_way      = match[1];
    assign victim_way   = lru[set];
    assign victim_dirty = dirty[set][lru[set]];  // dirty implies valid

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '{default: '0};
            dirty <= '{default: '0};
            lru   <= '{default: '0};
        end else begin
            // refilled line starts clean
            if (meta_fill) begin
                valid[set][fill_way] <= 1'b1;
                dirty[set][fill_way] <= 1'b0;
            end
            if (meta_clean) begin
                dirty[set][fill_way] <= 1'b0;  // victim written back
            end
            if (meta_touch) begin
                lru[set] <= ~hit_way;
                if (write) begin
                    dirty[set][hit_way] <= 1'b1;
                end
            end
        end
    end

endmodule

//--- src/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// line and set geometry
`define DC_ADDR_W    32
`define DC_LEN_LINE  4
`define DC_LEN_INDEX 4
`define DC_NR_WORDS  4
`define DC_NR_SETS   16

// address bits left over above index and line offset
`define DC_LEN_TAG   24

`endif

//--- src/dcache_pkg.sv
`include "dcache_params.svh"

package dcache_pkg;

    // field view of an address
    typedef struct packed {
        logic [`DC_LEN_TAG-1:0]   tag;
        logic [`DC_LEN_INDEX-1:0] index;
        logic [`DC_LEN_LINE-3:0]  word;  // word in line
        logic [1:0]               offs;  // byte in word
    } dc_addr_fields_t;

    typedef union packed {
        logic [`DC_ADDR_W-1:0] word;
        dc_addr_fields_t       f;
    } dc_addr_u;

    typedef struct packed {
        dc_addr_u    addr;
        logic        write;
        logic [3:0]  mask;
        logic [31:0] wdata;
    } cpu_req_t;

    // burst addresses, always line aligned
    typedef struct packed {
        dc_addr_u addr;
    } mem_ar_t;

    typedef struct packed {
        dc_addr_u addr;
    } mem_aw_t;

    typedef logic way_t;

endpackage

//--- src/dcache_top.sv
`include "dcache_params.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  dcache_pkg::cpu_req_t  cpu_req,
    output logic                  ack,
    output logic [31:0]           rdata,
    output logic                  ar_valid,
    output dcache_pkg::mem_ar_t   ar,
    input  logic                  ar_ready,
    input  logic                  r_valid,
    input  logic [31:0]           r_data,
    input  logic                  r_last,
    output logic                  r_ready,
    output logic                  aw_valid,
    output dcache_pkg::mem_aw_t   aw,
    input  logic                  aw_ready,
    output logic                  w_valid,
    output logic [31:0]           w_data,
    output logic                  w_last,
    input  logic                  w_ready
);
    import dcache_pkg::*;

    logic                        hit;
    way_t                        hit_way;
    way_t                        victim_way;
    logic                        victim_dirty;
    logic [1:0][`DC_LEN_TAG-1:0] tag_rd;
    logic [1:0][31:0]            rd_data;
    logic [`DC_LEN_INDEX-1:0]    ram_index;
    logic [`DC_LEN_LINE-3:0]     ram_word;
    way_t                        wr_way;
    logic [3:0]                  wr_mask;
    logic [31:0]                 wr_data;
    logic                        tag_we;
    logic                        meta_fill;
    logic                        meta_touch;
    logic                        meta_clean;

    dcache_ctrl u_ctrl (.victim_tag(tag_rd), .*);

    // fill and clean act on the way ctrl is writing
    dcache_meta u_meta (.addr(cpu_req.addr), .write(cpu_req.write), .fill_way(wr_way), .*);

    dcache_ways u_ways (.tag_wdata(cpu_req.addr.f.tag), .*);

endmodule

//--- src/dcache_ways.sv
`include "dcache_params.svh"

module dcache_ways (
    input  logic                          clk,
    input  logic [`DC_LEN_INDEX-1:0]      ram_index,
    input  logic [`DC_LEN_LINE-3:0]       ram_word,
    input  dcache_pkg::way_t              wr_way,
    input  logic [3:0]                    wr_mask,
    input  logic [31:0]                   wr_data,
    input  logic                          tag_we,
    input  logic [`DC_LEN_TAG-1:0]        tag_wdata,
    output logic [1:0][`DC_LEN_TAG-1:0]   tag_rd,
    output logic [1:0][31:0]              rd_data
);

    localparam int DEPTH = `DC_NR_SETS * `DC_NR_WORDS;

    logic [`DC_LEN_TAG-1:0] tag_mem  [2][`DC_NR_SETS];
    logic [31:0]            data_mem [2][DEPTH];

    logic [`DC_LEN_INDEX+`DC_LEN_LINE-3:0] word_addr;

    assign word_addr = {ram_index, ram_word};

    // one shared address for read and write
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (tag_we && (wr_way == 1'(w))) begin
                tag_mem[w][ram_index] <= tag_wdata;
            end
            for (int b = 0; b < 4; b++) begin
                if (wr_mask[b] && (wr_way == 1'(w))) begin
                    data_mem[w][word_addr][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
            tag_rd[w]  <= tag_mem[w][ram_index];   // old data on write
            rd_data[w] <= data_mem[w][word_addr];
        end
    end

endmodule

//--- testbench/tb_dcache.sv
`include "dcache_params.svh"

module tb_dcache;
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_pkg::*;

    localparam int NR_RANDOM   = 2000;
    localparam int NR_DIRECTED = 9;
    localparam int MAX_CYCLES  = (NR_RANDOM + NR_DIRECTED) * 64 + 200;  // 64 per worst miss

    logic        clk = 1'b0;
    logic        rst;
    logic        req;
    cpu_req_t    cpu_req;
    logic        ack;
    logic [31:0] rdata;
    logic        ar_valid;
    mem_ar_t     ar;
    logic        ar_ready;
    logic        r_valid;
    logic [31:0] r_data;
    logic        r_last;
    logic        r_ready;
    logic        aw_valid;
    mem_aw_t     aw;
    logic        aw_ready;
    logic        w_valid;
    logic [31:0] w_data;
    logic        w_last;
    logic        w_ready;
    int          rd_bursts;
    int          wr_bursts;
    dc_addr_u    last_aw;
    logic [`DC_NR_WORDS-1:0][31:0] wb_line;
    logic        burst_err;
    int          cycles = 0;

    logic [31:0] model [bit [31:0]];  // every word written so far

    dcache_top UUT (.*);

    tb_mem_slave u_mem (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] init_word(logic [31:0] a);
        return {a[15:0], a[31:16]} ^ ~a ^ 32'h3c5a_96e1;  // same fill as the memory
    endfunction

    function automatic logic [31:0] model_word(logic [31:0] a);
        return model.exists(a) ? model[a] : init_word(a);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h",
                                name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input dc_addr_u got, input dc_addr_u exp);
        if (got.word !== exp.word) begin
            abort_run($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h",
                                name, got.word, exp.word));
        end
    endtask

    task automatic check_quiet(input string when);
        if ({ack, ar_valid, aw_valid, w_valid, r_ready} !== 5'b0) begin
            abort_run({"ack or a bus valid/ready output is not low ", when});
        end
    endtask

    // one four-phase access with reads checked against the model
    task automatic do_access(input logic [31:0] a, input logic write,
                             input logic [3:0] mask, input logic [31:0] wdata);
        logic [31:0] exp_word;
        logic [31:0] got;
        exp_word = model_word(a);
        @(posedge clk);
        #1;
        cpu_req.addr.word = a;
        cpu_req.write     = write;
        cpu_req.mask      = mask;
        cpu_req.wdata     = wdata;
        req               = 1'b1;
        @(negedge clk);
        while (!ack) @(negedge clk);
        got = rdata;
        @(posedge clk);
        #1;
        req = 1'b0;
        @(negedge clk);
        while (ack) @(negedge clk);
        if (write) begin
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) exp_word[8*b +: 8] = wdata[8*b +: 8];
            end
            model[a] = exp_word;
        end else begin
            check_word("rdata", got, exp_word);
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) abort_run("timeout: the tests did not finish in time");
    end

    always @(negedge clk) begin
        if (burst_err === 1'b1) abort_run("the memory model saw a malformed bus burst");
    end

    initial begin
        logic [31:0] a;
        int          rd0;
        int          wr0;
        dc_addr_u    line_b;
        void'($urandom(97569));
        rst     = 1'b1;
        req     = 1'b0;
        cpu_req = '0;
        repeat (4) begin
            @(posedge clk);
            #1;
            check_quiet("during reset");
        end
        rst = 1'b0;
        @(negedge clk);
        check_quiet("after reset");

        // fresh line, then another word of it
        rd0 = rd_bursts;
        do_access(32'h0000_1024, 1'b0, 4'h0, '0);
        if (rd_bursts != rd0 + 1) abort_run("a read miss did not make exactly one read burst");
        do_access(32'h0000_1028, 1'b0, 4'h0, '0);
        if (rd_bursts != rd0 + 1) abort_run("a read hit caused a read burst");

        do_access(32'h0000_1028, 1'b1, 4'b1010, 32'hdead_beef);
        do_access(32'h0000_1028, 1'b0, 4'h0, '0);

        // tags a, b and c share set 5 and b ends up as the dirty LRU victim
        wr0 = wr_bursts;
        do_access(32'h0000_a054, 1'b1, 4'hf, 32'h1111_aaaa);
        do_access(32'h0000_b058, 1'b1, 4'b0011, 32'h2222_bbbb);
        do_access(32'h0000_a054, 1'b0, 4'h0, '0);
        if (wr_bursts != wr0) abort_run("a write burst came before any dirty eviction");
        do_access(32'h0000_c050, 1'b0, 4'h0, '0);
        if (wr_bursts != wr0 + 1) abort_run("a dirty eviction did not make one write burst");
        line_b.word = 32'h0000_b050;
        check_addr("aw.addr", last_aw, line_b);
        for (int w = 0; w < `DC_NR_WORDS; w++) begin
            check_word("w_data", wb_line[w], model_word(line_b.word + 32'(4 * w)));
        end
        do_access(32'h0000_b058, 1'b0, 4'h0, '0);

        // 4 tags over 2 sets
        for (int i = 0; i < NR_RANDOM; i++) begin
            a = 32'h0004_0000 | ($urandom_range(0, 3) << 8) | ($urandom_range(0, 1) << 4)
                | ($urandom_range(0, 3) << 2);
            do_access(a, 1'($urandom_range(0, 1)), 4'($urandom_range(0, 15)), $urandom());
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- testbench/tb_mem_slave.sv
`include "dcache_params.svh"

module tb_mem_slave (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          ar_valid,
    input  dcache_pkg::mem_ar_t           ar,
    output logic                          ar_ready,
    output logic                          r_valid,
    output logic [31:0]                   r_data,
    output logic                          r_last,
    input  logic                          r_ready,
    input  logic                          aw_valid,
    input  dcache_pkg::mem_aw_t           aw,
    output logic                          aw_ready,
    input  logic                          w_valid,
    input  logic [31:0]                   w_data,
    input  logic                          w_last,
    output logic                          w_ready,
    output int                            rd_bursts,
    output int                            wr_bursts,
    output dcache_pkg::dc_addr_u          last_aw,
    output logic [`DC_NR_WORDS-1:0][31:0] wb_line,
    output logic                          burst_err
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] ram [bit [31:0]];  // written words only
    logic [31:0] rd_base;
    logic [31:0] wr_base;
    int          rd_beat;
    int          wr_beat;
    logic        rd_busy;
    logic        wr_busy;

    function automatic logic [31:0] init_word(logic [31:0] a);
        return {a[15:0], a[31:16]} ^ ~a ^ 32'h3c5a_96e1;
    endfunction

    function automatic logic [31:0] fetch_word(logic [31:0] a);
        return ram.exists(a) ? ram[a] : init_word(a);
    endfunction

    function automatic logic random_ready();
        return $urandom_range(0, 3) != 0;  // ready three times in four
    endfunction

    task automatic flag_error(input string why);
        $display("memory model: %s", why);
        burst_err = 1'b1;
    endtask

    initial begin
        logic        ar_go;
        logic        r_go;
        logic        aw_go;
        logic        w_go;
        logic        end_beat;
        logic [31:0] ar_word;
        logic [31:0] aw_word;
        logic [31:0] w_word;
        {ar_ready, r_valid, r_last, aw_ready, w_ready, burst_err} = '0;
        r_data = '0;
        forever begin
            @(negedge clk);
            // handshakes that complete on the coming edge
            ar_go    = ar_valid && ar_ready;
            r_go     = r_valid && r_ready;
            aw_go    = aw_valid && aw_ready;
            w_go     = w_valid && w_ready;
            end_beat = w_last;
            ar_word  = ar.addr.word;
            aw_word  = aw.addr.word;
            w_word   = w_data;
            if (!rst && rd_busy && !r_ready) begin
                flag_error("r_ready low inside a read burst");
            end
            @(posedge clk);
            #1;
            if (rst) begin
                {rd_busy, wr_busy} = '0;
                {rd_base, wr_base} = '0;
                rd_beat   = 0;
                wr_beat   = 0;
                rd_bursts = 0;
                wr_bursts = 0;
                last_aw   = '0;
                wb_line   = '0;
            end else begin
                if (r_go) begin
                    if (rd_beat == `DC_NR_WORDS - 1) begin
                        rd_busy = 1'b0;
                        rd_bursts++;
                    end else begin
                        rd_beat++;
                    end
                end
                if (ar_go) begin
                    if (ar_word[`DC_LEN_LINE-1:0] != '0) begin
                        flag_error("read burst address is not line aligned");
                    end
                    rd_busy = 1'b1;
                    rd_base = ar_word;
                    rd_beat = 0;
                end
                if (aw_go) begin
                    if (aw_word[`DC_LEN_LINE-1:0] != '0) begin
                        flag_error("write burst address is not line aligned");
                    end
                    wr_busy      = 1'b1;
                    wr_base      = aw_word;
                    wr_beat      = 0;
                    last_aw.word = aw_word;
                end
                if (w_go) begin
                    if (!wr_busy || wr_beat >= `DC_NR_WORDS) begin
                        flag_error("write beat outside a burst");
                    end else begin
                        if (end_beat != (wr_beat == `DC_NR_WORDS - 1)) begin
                            flag_error("w_last does not mark the last beat");
                        end
                        ram[wr_base + 32'(4 * wr_beat)] = w_word;
                        wb_line[wr_beat] = w_word;
                        wr_beat++;
                        if (end_beat) begin
                            wr_busy = 1'b0;
                            wr_bursts++;
                        end
                    end
                end
            end
            ar_ready = !rst && !rd_busy && random_ready();
            r_valid  = !rst && rd_busy && random_ready();
            r_data   = fetch_word(rd_base + 32'(4 * rd_beat));
            r_last   = rd_busy && (rd_beat == `DC_NR_WORDS - 1);
            aw_ready = !rst && !wr_busy && random_ready();
            w_ready  = !rst && wr_busy && random_ready();
        end
    end

endmodule
